// ==== pdp8_top.f ====
+incdir+hdl
hdl/pdp8_bus_pkg.sv
hdl/pdp8_isa_pkg.sv
hdl/mem_port_if.sv
hdl/major_state_seq.sv
hdl/cpu_datapath.sv
hdl/memory_unit.sv
hdl/console_loader.sv
hdl/pdp8_top.sv
bench/pdp8_checker.sv
bench/pdp8_monitor.sv
bench/pdp8_tb.sv

// ==== Makefile ====
TOP = pdp8_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f pdp8_top.f --top-module pdp8_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f pdp8_top.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== bench/pdp8_tb.sv ====
`timescale 1ns/100ps
`include "pdp8_macros.svh"

module pdp8_tb import pdp8_isa_pkg::*, pdp8_bus_pkg::*;
();

    // every word deposited over all tests
    localparam int PROGRAM_WORDS = 54;
    localparam int TIMEOUT_CYCLES = PROGRAM_WORDS * 20 * 4;

    logic         clk;
    logic         reset;
    logic         run;
    logic         halt;
    logic         single_step;
    logic         int_req;
    logic         panel_trigger;
    word_t        panel_addr;
    word_t        panel_data;
    major_state_t state;
    word_t        pc;
    word_t        ac;
    logic         int_in_prog;
    logic         panel_busy;
    word_t        exp_ac;
    word_t        exp_pc;
    logic         exp_int;
    logic         step_hold;
    logic [31:0]  rng_state;
    int           cycles = 0;
    word_t        image [`PDP8_MEM_WORDS];

    pdp8_top i_pdp8_top (
        .clk(clk),
        .reset(reset),
        .run(run),
        .halt(halt),
        .single_step(single_step),
        .int_req(int_req),
        .panel_trigger(panel_trigger),
        .panel_addr(panel_addr),
        .panel_data(panel_data),
        .state(state),
        .pc(pc),
        .ac(ac),
        .int_in_prog(int_in_prog),
        .panel_busy(panel_busy)
    );

    pdp8_monitor mon (
        .clk(clk),
        .reset(reset),
        .state(state),
        .pc(pc),
        .ac(ac),
        .int_in_prog(int_in_prog),
        .exp_pc(exp_pc),
        .exp_ac(exp_ac),
        .exp_int(exp_int),
        .step_hold(step_hold)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic word_t rand_word();
        logic [31:0] r;
        r = lcg_next();
        return r[27:16];
    endfunction

    // instruction-level model, works on the shadow image; returns {interrupt taken, ac, pc}
    function automatic logic [24:0] pdp8_ref(input word_t start_pc, input word_t start_ac,
                                             input logic irq);
        word_t rpc;
        word_t rac;
        word_t here;
        word_t instr;
        addr_t ea;
        logic  ena;
        logic  inh;
        logic  took;
        int    n;
        rpc = start_pc;
        rac = start_ac;
        ena = 1'b0;
        inh = 1'b0;
        took = 1'b0;
        for (n = 0; n < 1000; n++)
        begin
            here = rpc;
            instr = image[here];
            rpc = rpc + 12'd1;
            inh = 1'b0;
            if (instr == 12'o7402)
                break;
            case (instr[11:9])
                3'o6:
                begin
                    if (instr == 12'o6001)
                    begin
                        ena = 1'b1;
                        inh = 1'b1;
                    end
                    else if (instr == 12'o6002)
                        ena = 1'b0;
                end
                3'o7:
                begin
                    if (!instr[8])
                    begin
                        if (instr[7])
                            rac = '0;
                        rac = rac + word_t'(instr[0]);
                    end
                end
                default:
                begin
                    ea = instr[7] ? {here[11:7], instr[6:0]} : {5'b0, instr[6:0]};
                    if (instr[8])
                        ea = image[ea];
                    case (instr[11:9])
                        3'o0: rac = rac & image[ea];
                        3'o1: rac = rac + image[ea];
                        3'o3:
                        begin
                            image[ea] = rac;
                            rac = '0;
                        end
                        3'o5: rpc = ea;
                        default: ;
                    endcase
                end
            endcase
            // IOF never lets a request through
            if (irq && ena && !inh && instr != 12'o6002)
            begin
                image[`PDP8_INT_SAVE] = rpc;
                rpc = word_t'(`PDP8_INT_VECTOR);
                ena = 1'b0;
                took = 1'b1;
            end
        end
        return {took, rac, rpc};
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic do_reset();
        reset = 1'b1;
        repeat (5) step();
        reset = 1'b0;
    endtask

    task automatic deposit(input addr_t a, input word_t d);
        image[a] = d;
        panel_addr = a;
        panel_data = d;
        panel_trigger = 1'b1;
        do step(); while (!panel_busy);
        panel_trigger = 1'b0;
        do step(); while (panel_busy);
    endtask

    task automatic expect_run(input word_t start_pc, input word_t start_ac, input logic irq);
        logic [24:0] r;
        r = pdp8_ref(start_pc, start_ac, irq);
        exp_int = r[24];
        exp_ac = r[23:12];
        exp_pc = r[11:0];
    endtask

    task automatic run_program();
        do step(); while (state != HW);
        run = 1'b1;
        step();
        run = 1'b0;
        do step(); while (state != H0);
        // the monitor samples the halted state on the next edge
        step();
    endtask

    task automatic confirm_word(input addr_t a);
        mon.check_value($sformatf("core[%o]", a), int'(i_pdp8_top.i_memory_unit.core[a]),
                        int'(image[a]));
    endtask

    task automatic step_through(output int stops);
        logic done;
        stops = 0;
        done = 1'b0;
        do step(); while (state != HW);
        run = 1'b1;
        step();
        run = 1'b0;
        while (!done)
        begin
            while (!(state inside {F0, D0, E0, H0, HW}))
                step();
            if (state == H0 || state == HW)
                done = 1'b1;
            else
            begin
                if (state == F0)
                begin
                    stops++;
                    step_hold = 1'b1;
                    repeat (3) step();
                    step_hold = 1'b0;
                end
                run = 1'b1;
                step();
                run = 1'b0;
            end
        end
        step();
        step();
    endtask

    initial
    begin
        int    i;
        int    stops;
        int    total_errors;
        int    assert_fails;
        logic [31:0] r;
        logic [2:0]  op;
        reset = 1'b1;
        run = 1'b0;
        halt = 1'b0;
        single_step = 1'b0;
        int_req = 1'b0;
        panel_trigger = 1'b0;
        panel_addr = '0;
        panel_data = '0;
        exp_ac = '0;
        exp_pc = '0;
        exp_int = 1'b0;
        step_hold = 1'b0;
        rng_state = 32'hc00171c7;

        // random operands at 0100..0107
        do_reset();
        for (i = 0; i < 8; i++)
            deposit(addr_t'('o100 + i), rand_word());
        deposit('o200, 'o7200);
        for (i = 0; i < 8; i++)
        begin
            r = lcg_next();
            case (int'(r[15:8]) % 3)
                0: op = 3'o0;
                1: op = 3'o1;
                default: op = 3'o3;
            endcase
            deposit(addr_t'('o201 + i), {op, 3'o1, 3'o0, r[2:0]});
        end
        deposit('o211, 'o7402);
        expect_run('o200, '0, 1'b0);
        run_program();
        mon.end_test(1, "random tad/and/dca");

        do_reset();
        deposit('o300, rand_word());
        deposit('o301, rand_word());
        deposit('o020, 'o300);
        deposit('o021, 'o301);
        deposit('o022, 'o240);
        deposit('o200, 'o7200);
        deposit('o201, 'o1420);
        deposit('o202, 'o1421);
        deposit('o203, 'o5422);
        deposit('o240, 'o0420);
        deposit('o241, 'o7402);
        expect_run('o200, '0, 1'b0);
        run_program();
        mon.end_test(2, "indirect tad and jmp");

        do_reset();
        deposit('o110, rand_word());
        deposit('o111, rand_word());
        confirm_word('o110);
        confirm_word('o111);
        deposit('o200, 'o7200);
        deposit('o201, 'o1110);
        deposit('o202, 'o1111);
        deposit('o203, 'o3112);
        deposit('o204, 'o7402);
        expect_run('o200, '0, 1'b0);
        run_program();
        confirm_word('o112);
        // second program continues from the halt address
        deposit('o205, 'o1112);
        deposit('o206, 'o7402);
        expect_run('o205, '0, 1'b0);
        run_program();
        mon.end_test(3, "dca read back");

        do_reset();
        single_step = 1'b1;
        deposit('o120, rand_word());
        deposit('o121, rand_word());
        deposit('o200, 'o7200);
        deposit('o201, 'o1120);
        deposit('o202, 'o7001);
        deposit('o203, 'o1121);
        deposit('o204, 'o7402);
        expect_run('o200, '0, 1'b0);
        step_through(stops);
        mon.check_value("stops in F0", stops, 5);
        single_step = 1'b0;
        mon.end_test(4, "single step");

        do_reset();
        deposit('o001, 'o7200);
        deposit('o002, 'o1000);
        deposit('o003, 'o7402);
        deposit('o200, 'o6001);
        deposit('o201, 'o5201);
        int_req = 1'b1;
        expect_run('o200, '0, 1'b1);
        run_program();
        int_req = 1'b0;
        mon.end_test(5, "interrupt from loop");

        do_reset();
        deposit('o200, 'o6001);
        deposit('o201, 'o6002);
        deposit('o202, 'o7201);
        deposit('o203, 'o7402);
        int_req = 1'b1;
        expect_run('o200, '0, 1'b1);
        run_program();
        int_req = 1'b0;
        mon.end_test(6, "iof blocks interrupt");

        assert_fails = i_pdp8_top.i_major_state_seq.i_checker.fail_count;
        total_errors = mon.error_count + assert_fails;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 mon.test_count, mon.check_count, mon.error_count, assert_fails);
        if (total_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== bench/pdp8_monitor.sv ====
`timescale 1ns/100ps

module pdp8_monitor import pdp8_isa_pkg::*, pdp8_bus_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input major_state_t state,
    input word_t        pc,
    input word_t        ac,
    input logic         int_in_prog,
    input word_t        exp_pc,
    input word_t        exp_ac,
    input logic         exp_int,
    input logic         step_hold
);

    int   check_count = 0;
    int   error_count = 0;
    int   test_errors = 0;
    int   test_count = 0;
    logic was_running = 1'b0;
    logic saw_int = 1'b0;

    task automatic check_value(input string what, input int got, input int want);
        check_count++;
        if (got != want)
        begin
            error_count++;
            test_errors++;
            $display("Error at %0t ns: %s is %o, expected %o", $time, what, got, want);
        end
    endtask

    task automatic end_test(input int num, input string name);
        test_count++;
        if (test_errors == 0)
            $display("test %0d (%s): ok", num, name);
        else
            $display("test %0d (%s): %0d errors", num, name, test_errors);
        test_errors = 0;
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            was_running = 1'b0;
            saw_int = 1'b0;
        end
        else if (!(state inside {H0, HW, H1, H2, H3}))
        begin
            was_running = 1'b1;
            if (int_in_prog)
                saw_int = 1'b1;
        end
        else if (state == H0 && was_running)
        begin
            // a run has just halted
            was_running = 1'b0;
            check_value("ac at halt", int'(ac), int'(exp_ac));
            check_value("pc at halt", int'(pc), int'(exp_pc));
            check_value("interrupt taken", int'(saw_int), int'(exp_int));
            saw_int = 1'b0;
        end
        if (!reset && step_hold)
            check_value("state while stepping", int'(state), int'(F0));
    end

endmodule

// ==== bench/pdp8_checker.sv ====
`timescale 1ns/100ps

module pdp8_checker import pdp8_isa_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input logic         mem_done,
    input logic         int_in_prog,
    input major_state_t state
);

    int fail_count = 0;

    // a memory wait state is only left once the four-phase cycle is over
    wait_needs_done: assert property (@(posedge clk) disable iff (reset)
        (state inside {FW, DW, EW} && !mem_done) |=> state == $past(state))
        else
        begin
            fail_count++;
            $error("wait state left without mem_done");
        end

    int_rises_in_e0: assert property (@(posedge clk) disable iff (reset)
        $rose(int_in_prog) |-> state == E0)
        else
        begin
            fail_count++;
            $error("int_in_prog rose outside E0");
        end

    reset_to_h0: assert property (@(posedge clk)
        reset |=> state == H0)
        else
        begin
            fail_count++;
            $error("reset did not lead to H0");
        end

endmodule

bind major_state_seq pdp8_checker i_checker (
    .clk(clk),
    .reset(reset),
    .mem_done(mem_done),
    .int_in_prog(int_in_prog),
    .state(state)
);

// ==== hdl/pdp8_top.sv ====
`timescale 1ns/100ps

module pdp8_top import pdp8_isa_pkg::*, pdp8_bus_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         run,
    input  logic         halt,
    input  logic         single_step,
    input  logic         int_req,
    input  logic         panel_trigger,
    input  word_t        panel_addr,
    input  word_t        panel_data,
    output major_state_t state,
    output word_t        pc,
    output word_t        ac,
    output logic         int_in_prog,
    output logic         panel_busy
);

    word_t ir;
    logic  mem_done;
    logic  int_ena;
    logic  int_inh;
    logic  panel_done;
    logic  panel_start;

    mem_port_if cpu_port();
    mem_port_if panel_port();

    // the deposit runs while the sequencer passes H1
    assign panel_start = (state == H1);

    major_state_seq i_major_state_seq (
        .clk(clk),
        .reset(reset),
        .halt(halt),
        .single_step(single_step),
        .cont(run),
        .int_req(int_req),
        .int_ena(int_ena),
        .int_inh(int_inh),
        .trigger(panel_trigger),
        .mem_done(mem_done),
        .panel_done(panel_done),
        .instruction(ir),
        .state(state),
        .int_in_prog(int_in_prog)
    );

    cpu_datapath i_cpu_datapath (
        .clk(clk),
        .reset(reset),
        .state(state),
        .int_in_prog(int_in_prog),
        .ir(ir),
        .pc(pc),
        .ac(ac),
        .int_ena(int_ena),
        .int_inh(int_inh),
        .mem_done(mem_done),
        .mem(cpu_port.requester)
    );

    memory_unit i_memory_unit (
        .clk(clk),
        .reset(reset),
        .cpu_port(cpu_port.memory),
        .panel_port(panel_port.memory)
    );

    console_loader i_console_loader (
        .clk(clk),
        .reset(reset),
        .start(panel_start),
        .panel_addr(panel_addr),
        .panel_data(panel_data),
        .panel_busy(panel_busy),
        .panel_done(panel_done),
        .mem(panel_port.requester)
    );

endmodule

// ==== hdl/console_loader.sv ====
`timescale 1ns/100ps

module console_loader import pdp8_bus_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  word_t panel_addr,
    input  word_t panel_data,
    output logic  panel_busy,
    output logic  panel_done,
    mem_port_if.requester mem
);

    typedef enum logic [1:0] {LD_IDLE, LD_REQ, LD_DROP} ld_state_t;

    ld_state_t ld_state;
    addr_t     addr_q;
    word_t     data_q;

    assign mem.req = (ld_state == LD_REQ);
    assign mem.we = 1'b1;
    assign mem.addr = addr_q;
    assign mem.wdata = data_q;
    assign panel_busy = (ld_state != LD_IDLE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ld_state <= LD_IDLE;
            panel_done <= 1'b0;
        end
        else
        begin
            panel_done <= 1'b0;
            case (ld_state)
                LD_IDLE: if (start) ld_state <= LD_REQ;
                LD_REQ: if (mem.ack) ld_state <= LD_DROP;
                default:
                begin
                    // deposit is over once ack falls
                    if (!mem.ack)
                    begin
                        ld_state <= LD_IDLE;
                        panel_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start && ld_state == LD_IDLE)
        begin
            addr_q <= addr_t'(panel_addr);
            data_q <= panel_data;
        end
    end

endmodule

// ==== hdl/memory_unit.sv ====
`timescale 1ns/100ps
`include "pdp8_macros.svh"

module memory_unit import pdp8_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    mem_port_if.memory cpu_port,
    mem_port_if.memory panel_port
);

    word_t  core [`PDP8_MEM_WORDS];
    grant_t grant;
    logic   ack_q;
    word_t  rd_q;
    logic   sel_req;
    logic   sel_we;
    addr_t  sel_addr;
    word_t  sel_wdata;

    always_comb
    begin
        sel_req = 1'b0;
        sel_we = cpu_port.we;
        sel_addr = cpu_port.addr;
        sel_wdata = cpu_port.wdata;
        if (grant == GNT_CPU)
            sel_req = cpu_port.req;
        else if (grant == GNT_PANEL)
        begin
            sel_req = panel_port.req;
            sel_we = panel_port.we;
            sel_addr = panel_port.addr;
            sel_wdata = panel_port.wdata;
        end
    end

    assign cpu_port.ack = ack_q && (grant == GNT_CPU);
    assign panel_port.ack = ack_q && (grant == GNT_PANEL);
    assign cpu_port.rdata = rd_q;
    assign panel_port.rdata = rd_q;

    // cpu has priority, the winner holds the grant until its ack drops
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grant <= GNT_NONE;
            ack_q <= 1'b0;
        end
        else if (grant == GNT_NONE)
        begin
            if (cpu_port.req)
                grant <= GNT_CPU;
            else if (panel_port.req)
                grant <= GNT_PANEL;
        end
        else if (!ack_q && sel_req)
            ack_q <= 1'b1;
        else if (ack_q && !sel_req)
        begin
            ack_q <= 1'b0;
            grant <= GNT_NONE;
        end
    end

    always_ff @(posedge clk)
    begin
        if (sel_req && !ack_q)
        begin
            if (sel_we)
                core[sel_addr] <= sel_wdata;
            rd_q <= core[sel_addr];
        end
    end

endmodule

// ==== hdl/cpu_datapath.sv ====
`timescale 1ns/100ps
`include "pdp8_macros.svh"

module cpu_datapath import pdp8_isa_pkg::*, pdp8_bus_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  major_state_t state,
    input  logic         int_in_prog,
    output word_t        ir,
    output word_t        pc,
    output word_t        ac,
    output logic         int_ena,
    output logic         int_inh,
    output logic         mem_done,
    mem_port_if.requester mem
);

    typedef enum logic [1:0] {CYC_IDLE, CYC_REQ, CYC_DROP, CYC_DONE} cyc_t;

    cyc_t    cyc;
    addr_t   ma;
    word_t   md;
    opcode_t op;
    addr_t   ea;
    logic    launch;
    logic    write_cyc;

    assign op = op_of(ir);
    assign launch = (cyc == CYC_IDLE) && (state == FW || state == DW || state == EW);
    assign write_cyc = (state == EW) && (int_in_prog || op == DCA);
    assign mem_done = (cyc == CYC_DONE);
    assign mem.addr = ma;

    // current page comes from the fetch address still held in ma
    assign ea = ir[`PDP8_PAGE_BIT] ?
                {ma[`PDP8_ADDR_W-1:`PDP8_OFF_HI+1], ir[`PDP8_OFF_HI:0]} :
                addr_t'(ir[`PDP8_OFF_HI:0]);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cyc <= CYC_IDLE;
            mem.req <= 1'b0;
            pc <= word_t'(`PDP8_START_PC);
            ac <= '0;
            int_ena <= 1'b0;
            int_inh <= 1'b0;
        end
        else
        begin
            case (cyc)
                CYC_IDLE:
                begin
                    if (launch)
                    begin
                        mem.req <= 1'b1;
                        cyc <= CYC_REQ;
                    end
                end
                CYC_REQ:
                begin
                    if (mem.ack)
                    begin
                        mem.req <= 1'b0;
                        cyc <= CYC_DROP;
                    end
                end
                CYC_DROP: if (!mem.ack) cyc <= CYC_DONE;
                default: cyc <= CYC_IDLE;
            endcase

            case (state)
                F1:
                begin
                    pc <= pc + 1'b1;
                    int_inh <= 1'b0;
                end
                F2:
                begin
                    if (op == JMP && !is_indirect(ir))
                        pc <= ea;
                    else if (ir == INSTR_ION)
                    begin
                        int_ena <= 1'b1;
                        int_inh <= 1'b1;
                    end
                    else if (ir == INSTR_IOF)
                        int_ena <= 1'b0;
                    else if (op == OPR && !ir[`PDP8_IND_BIT])
                        ac <= (ir[`PDP8_CLA_BIT] ? '0 : ac) + word_t'(ir[`PDP8_IAC_BIT]);
                end
                D2: if (op == JMP) pc <= md;
                E2:
                begin
                    if (int_in_prog)
                    begin
                        pc <= word_t'(`PDP8_INT_VECTOR);
                        int_ena <= 1'b0;
                    end
                    else if (op == AND)
                        ac <= ac & md;
                    else if (op == TAD)
                        ac <= ac + md;
                    else if (op == DCA)
                        ac <= '0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            mem.we <= write_cyc;
            mem.wdata <= int_in_prog ? pc : ac;
            if (state == FW)
                ma <= pc;
            else if (state == EW && int_in_prog)
                ma <= addr_t'(`PDP8_INT_SAVE);
        end
        if (cyc == CYC_REQ && mem.ack)
            md <= mem.rdata;
        case (state)
            F1: ir <= md;
            F2: ma <= ea;
            // indirect operand address comes from the pointer word
            D2: if (op != JMP) ma <= md;
            default: ;
        endcase
    end

endmodule

// ==== hdl/major_state_seq.sv ====
`timescale 1ns/100ps

module major_state_seq import pdp8_isa_pkg::*, pdp8_bus_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         halt,
    input  logic         single_step,
    input  logic         cont,
    input  logic         int_req,
    input  logic         int_ena,
    input  logic         int_inh,
    input  logic         trigger,
    input  logic         mem_done,
    input  logic         panel_done,
    input  word_t        instruction,
    output major_state_t state,
    output logic         int_in_prog
);

    opcode_t op;
    logic    go;
    logic    int_take;
    logic    fetch_exec;

    assign op = op_of(instruction);
    assign go = ~single_step | cont;
    assign int_take = int_req & int_ena & ~int_inh;
    // IOT, OPR and direct JMP complete in the fetch cycle
    assign fetch_exec = (op == IOT) || (op == OPR) ||
                        (op == JMP && !is_indirect(instruction));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= H0;
            int_in_prog <= 1'b0;
        end
        else
        begin
            case (state)
                F0:
                begin
                    int_in_prog <= 1'b0;
                    if (go)
                        state <= FW;
                end
                FW: if (mem_done) state <= F1;
                F1: state <= F2;
                F2: state <= F3;
                F3:
                begin
                    if (fetch_exec)
                    begin
                        if (halt || instruction == INSTR_HLT)
                            state <= H0;
                        else if (int_take && instruction != INSTR_IOF)
                        begin
                            // an IOF just fetched wins over a pending request
                            int_in_prog <= 1'b1;
                            state <= E0;
                        end
                        else
                            state <= F0;
                    end
                    else if (is_indirect(instruction))
                        state <= D0;
                    else
                        state <= E0;
                end
                D0: if (go) state <= DW;
                DW: if (mem_done) state <= D1;
                D1: state <= D2;
                D2: state <= D3;
                D3:
                begin
                    // JMP I is finished once the pointer is read
                    if (op != JMP)
                        state <= E0;
                    else if (int_take)
                    begin
                        int_in_prog <= 1'b1;
                        state <= E0;
                    end
                    else if (halt)
                        state <= H0;
                    else
                        state <= F0;
                end
                E0: if (go) state <= EW;
                EW: if (mem_done) state <= E1;
                E1: state <= E2;
                E2: state <= E3;
                E3:
                begin
                    if (halt)
                        state <= H0;
                    else if (int_in_prog)
                        state <= F0;
                    else if (int_take)
                    begin
                        int_in_prog <= 1'b1;
                        state <= E0;
                    end
                    else
                        state <= F0;
                end
                H0: state <= HW;
                HW:
                begin
                    if (trigger & ~cont)
                        state <= H1;
                    else if (~cont)
                        state <= H0;
                    else
                        state <= F0;
                end
                H1: state <= H2;
                H2: if (panel_done) state <= H3;
                H3: state <= H0;
                default: state <= H0;
            endcase
        end
    end

endmodule

// ==== hdl/mem_port_if.sv ====
`timescale 1ns/100ps

interface mem_port_if import pdp8_bus_pkg::*; ();

    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;
    logic  ack;

    // four-phase: req up, ack up, req down, ack down
    modport requester (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    modport memory (
        input  req, we, addr, wdata,
        output rdata, ack
    );

endinterface

// ==== hdl/pdp8_isa_pkg.sv ====
package pdp8_isa_pkg;
`include "pdp8_macros.svh"

    localparam int MAJOR_LEN = `PDP8_TSTATES + 1;

    typedef enum logic [4:0] {
        F0 = 5'd0, FW, F1, F2, F3,
        D0 = 5'(MAJOR_LEN), DW, D1, D2, D3,
        E0 = 5'(2 * MAJOR_LEN), EW, E1, E2, E3,
        H0 = 5'(3 * MAJOR_LEN), HW, H1, H2, H3
    } major_state_t;

    typedef enum logic [2:0] {AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR} opcode_t;

    localparam logic [`PDP8_WORD_W-1:0] INSTR_ION = 'o6001;
    localparam logic [`PDP8_WORD_W-1:0] INSTR_IOF = 'o6002;
    localparam logic [`PDP8_WORD_W-1:0] INSTR_HLT = 'o7402;

    function automatic opcode_t op_of(input logic [`PDP8_WORD_W-1:0] instr);
        return opcode_t'(instr[`PDP8_OP_HI:`PDP8_OP_LO]);
    endfunction

    function automatic logic is_indirect(input logic [`PDP8_WORD_W-1:0] instr);
        return instr[`PDP8_IND_BIT];
    endfunction

endpackage

// ==== hdl/pdp8_bus_pkg.sv ====
package pdp8_bus_pkg;
`include "pdp8_macros.svh"

    typedef logic [`PDP8_WORD_W-1:0] word_t;
    typedef logic [`PDP8_ADDR_W-1:0] addr_t;

    // current owner of the core array
    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_CPU,
        GNT_PANEL
    } grant_t;

endpackage

// ==== hdl/pdp8_macros.svh ====
`ifndef PDP8_MACROS_SVH
`define PDP8_MACROS_SVH

`define PDP8_WORD_W     12
`define PDP8_ADDR_W     12
`define PDP8_MEM_WORDS  4096

// time states per major state, the wait state not counted
`define PDP8_TSTATES    4

// instruction fields, bit 0 is the least significant bit
`define PDP8_OP_HI      11
`define PDP8_OP_LO      9
`define PDP8_IND_BIT    8
`define PDP8_PAGE_BIT   7
`define PDP8_OFF_HI     6
`define PDP8_CLA_BIT    7
`define PDP8_IAC_BIT    0

`define PDP8_INT_SAVE   0
`define PDP8_INT_VECTOR 1
// first instruction after reset
`define PDP8_START_PC   'o0200

`endif
